//--- source/dsi_pkg.sv
`default_nettype none

package dsi_pkg;

    typedef logic [7:0]  data_id_t;                 // virtual channel in bits 7..6, data type below
    typedef logic [15:0] word_count_t;              // payload bytes of a long packet
    typedef logic [7:0]  ecc_t;                     // bits 7..6 are always zero
    typedef logic [15:0] crc_t;
    typedef logic [3:0]  strb_t;                    // bit i qualifies byte lane i

    typedef enum logic [1:0] {
        PKT_SHORT,
        PKT_LONG,
        PKT_RESERVED
    } packet_kind_e;

    // content of the next output word
    typedef enum logic [1:0] {
        SRC_HEADER,
        SRC_PAYLOAD,
        SRC_CRC_TAIL
    } lane_source_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND_HEADER,
        ST_FETCH_PAYLOAD,
        ST_SEND_PAYLOAD,
        ST_SEND_CRC_TAIL
    } seq_state_e;

    localparam crc_t CRC_SEED           = 16'hFFFF;
    localparam crc_t CRC_POLY_REFLECTED = 16'h8408;   // x^16 + x^12 + x^5 + 1, lsb first

endpackage

`default_nettype wire

//--- source/ecc_calc.sv
`default_nettype none

module ecc_calc (
    input  wire [23:0]     data,                    // header as held in the fifo word
    output dsi_pkg::ecc_t  ecc_result
);

    // header bits that feed parity bits p0 to p5, in link byte order
    localparam logic [23:0] PARITY_MASK [6] = '{
        24'hF12CB7,
        24'hF2555B,
        24'h749A6D,
        24'hB8E38E,
        24'hDF03F0,
        24'hEFFC00
    };

    logic [23:0] link_bits;

    // the link sends the data id first, then the low and the high word count byte
    assign link_bits = {data[15:0], data[23:16]};

    always_comb
    begin
        ecc_result = '0;                            // the top two bits stay zero
        for (int k = 0; k < 6; k++)
        begin
            ecc_result[k] = ^(link_bits & PARITY_MASK[k]);
        end
    end

endmodule

`default_nettype wire

//--- source/crc_calculator.sv
`default_nettype none

module crc_calculator (
    input  wire            clk_sys,
    input  wire            reset_stop_read_data_hs,
    input  wire            clear,
    input  wire            data_write,
    input  wire [2:0]      bytes_number,            // 0 to 4 valid lanes starting from lane 0
    input  wire [31:0]     data_input,
    output dsi_pkg::crc_t  crc_next,
    output dsi_pkg::crc_t  crc
);
    import dsi_pkg::*;

    // one byte through the reflected ccitt polynomial, lsb first
    function automatic crc_t crc_byte(input crc_t crc_in, input logic [7:0] data_byte);
        crc_t c;
        c = crc_in ^ {8'h00, data_byte};
        for (int b = 0; b < 8; b++)
        begin
            if (c[0])
                c = (c >> 1) ^ CRC_POLY_REFLECTED;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    always_comb
    begin
        crc_t c;
        c = crc;
        for (int i = 0; i < 4; i++)
        begin
            if (i < bytes_number)
                c = crc_byte(c, data_input[8*i +: 8]);
        end
        crc_next = c;                               // includes the word on data_input
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset_stop_read_data_hs || clear)
            crc <= CRC_SEED;
        else if (data_write)
            crc <= crc_next;
    end

endmodule

`default_nettype wire

//--- source/payload_packer.sv
`default_nettype none

module payload_packer (
    input  wire                    clk_sys,
    input  wire                    reset_stop_read_data_hs,
    input  wire                    load_word,
    input  dsi_pkg::lane_source_e  lane_source,
    input  wire [2:0]              payload_bytes,
    input  wire                    crc_high_only,
    input  wire [31:0]             usr_fifo_data,
    input  dsi_pkg::ecc_t          ecc_result,
    input  dsi_pkg::crc_t          crc_next,
    input  dsi_pkg::crc_t          crc,
    output logic [31:0]            iface_write_data,
    output dsi_pkg::strb_t         iface_write_strb
);
    import dsi_pkg::*;

    logic [31:0] next_data;
    strb_t       next_strb;

    always_comb
    begin
        next_data = '0;                             // lanes left unused go out as zero
        next_strb = '0;
        case (lane_source)
            SRC_HEADER:
            begin
                next_data = {ecc_result, usr_fifo_data[15:8], usr_fifo_data[7:0],
                             usr_fifo_data[23:16]};
                next_strb = 4'b1111;
            end
            SRC_PAYLOAD:
            begin
                // a short last word takes as many crc bytes as still fit behind the payload
                for (int i = 0; i < 4; i++)
                begin
                    if (i < payload_bytes)
                        next_data[8*i +: 8] = usr_fifo_data[8*i +: 8];
                    else if (i == payload_bytes)
                        next_data[8*i +: 8] = crc_next[7:0];
                    else if (i == payload_bytes + 1)
                        next_data[8*i +: 8] = crc_next[15:8];
                    next_strb[i] = (i < payload_bytes + 2);
                end
            end
            SRC_CRC_TAIL:
            begin
                if (crc_high_only)
                begin
                    next_data = {24'h000000, crc[15:8]};  // low byte already went out
                    next_strb = 4'b0001;
                end
                else
                begin
                    next_data = {16'h0000, crc};
                    next_strb = 4'b0011;
                end
            end
            default:
                next_data = '0;
        endcase
    end

    always_ff @(posedge clk_sys)
    begin
        if (load_word)
            iface_write_data <= next_data;
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset_stop_read_data_hs)
            iface_write_strb <= '0;
        else if (load_word)
            iface_write_strb <= next_strb;
    end

endmodule

`default_nettype wire

//--- source/packet_sequencer.sv
`default_nettype none

module packet_sequencer (
    input  wire                    clk_sys,
    input  wire                    reset_stop_read_data_hs,
    input  wire [31:0]             usr_fifo_data,
    input  wire                    usr_fifo_empty,
    input  wire                    iface_data_rqst,
    output logic                   usr_fifo_read,
    output logic                   iface_write_rqst,
    output logic                   iface_last_word,
    output logic                   packet_error,
    output dsi_pkg::lane_source_e  lane_source,
    output logic [2:0]             payload_bytes,
    output logic                   crc_high_only,
    output logic                   load_word,
    output logic                   crc_clear,
    output logic                   crc_update
);
    import dsi_pkg::*;

    seq_state_e   state;
    packet_kind_e header_kind;
    word_count_t  header_wc;
    logic [16:0]  bytes_left;                       // payload plus crc bytes still to send
    logic [16:0]  payload_left;
    logic [2:0]   word_bytes;
    logic         header_pop;
    logic         payload_pop;
    logic         tail_load;
    logic         word_accepted;

    function automatic packet_kind_e classify(input data_id_t data_id);
        if (data_id[3:0] == 4'h0 || data_id[3:0] == 4'hF)
            return PKT_RESERVED;
        else if (data_id[3] && (data_id[2:0] != 3'b000))
            return PKT_LONG;
        else
            return PKT_SHORT;
    endfunction

    assign header_kind   = classify(usr_fifo_data[23:16]);
    assign header_wc     = usr_fifo_data[15:0];
    assign payload_left  = (bytes_left > 17'd2) ? bytes_left - 17'd2 : 17'd0;
    assign payload_bytes = (payload_left >= 17'd4) ? 3'd4 : payload_left[2:0];
    assign word_bytes    = (bytes_left >= 17'd4) ? 3'd4 : bytes_left[2:0];
    assign crc_high_only = (bytes_left == 17'd1);  // crc low byte went out with the payload

    assign header_pop    = (state == ST_IDLE) && !usr_fifo_empty;
    assign payload_pop   = (state == ST_FETCH_PAYLOAD) && (bytes_left > 17'd2) && !usr_fifo_empty;
    assign tail_load     = (state == ST_FETCH_PAYLOAD) && (bytes_left <= 17'd2);
    assign word_accepted = iface_write_rqst && iface_data_rqst;

    assign usr_fifo_read = header_pop || payload_pop;
    assign load_word     = (header_pop && header_kind != PKT_RESERVED) || payload_pop || tail_load;
    assign crc_clear     = header_pop;
    assign crc_update    = payload_pop;

    always_comb
    begin
        if (state == ST_IDLE)
            lane_source = SRC_HEADER;
        else if (bytes_left > 17'd2)
            lane_source = SRC_PAYLOAD;
        else
            lane_source = SRC_CRC_TAIL;
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset_stop_read_data_hs)
        begin
            state            <= ST_IDLE;
            iface_write_rqst <= 1'b0;
            iface_last_word  <= 1'b0;
            packet_error     <= 1'b0;
            bytes_left       <= '0;
        end
        else
        begin
            packet_error <= header_pop && (header_kind == PKT_RESERVED);  // header is dropped
            case (state)
                ST_IDLE:
                begin
                    if (header_pop && header_kind != PKT_RESERVED)
                    begin
                        state            <= ST_SEND_HEADER;
                        iface_write_rqst <= 1'b1;
                        iface_last_word  <= (header_kind == PKT_SHORT);
                        bytes_left       <= {1'b0, header_wc} + 17'd2;
                    end
                end
                ST_FETCH_PAYLOAD:
                begin
                    // waits here while the fifo is empty in the middle of a payload
                    if (payload_pop || tail_load)
                    begin
                        state            <= payload_pop ? ST_SEND_PAYLOAD : ST_SEND_CRC_TAIL;
                        iface_write_rqst <= 1'b1;
                        iface_last_word  <= (bytes_left <= 17'd4);
                        bytes_left       <= bytes_left - word_bytes;
                    end
                end
                ST_SEND_HEADER, ST_SEND_PAYLOAD, ST_SEND_CRC_TAIL:
                begin
                    if (word_accepted)                // flags hold until the word is taken
                    begin
                        state            <= iface_last_word ? ST_IDLE : ST_FETCH_PAYLOAD;
                        iface_write_rqst <= 1'b0;
                        iface_last_word  <= 1'b0;
                    end
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/packets_assembler.sv
`default_nettype none

module packets_assembler (
    input  wire             clk_sys,
    input  wire             reset_stop_read_data_hs,
    input  wire [31:0]      usr_fifo_data,
    input  wire             usr_fifo_empty,
    input  wire             iface_data_rqst,
    output logic            usr_fifo_read,
    output logic [31:0]     iface_write_data,
    output dsi_pkg::strb_t  iface_write_strb,
    output logic            iface_write_rqst,
    output logic            iface_last_word,
    output logic            packet_error
);
    import dsi_pkg::*;

    lane_source_e lane_source;
    logic [2:0]   payload_bytes;
    logic         crc_high_only;
    logic         load_word;
    logic         crc_clear;
    logic         crc_update;
    ecc_t         ecc_result;
    crc_t         crc_next;
    crc_t         crc;

    packet_sequencer u_sequencer (
        .clk_sys                 (clk_sys),
        .reset_stop_read_data_hs (reset_stop_read_data_hs),
        .usr_fifo_data           (usr_fifo_data),
        .usr_fifo_empty          (usr_fifo_empty),
        .iface_data_rqst         (iface_data_rqst),
        .usr_fifo_read           (usr_fifo_read),
        .iface_write_rqst        (iface_write_rqst),
        .iface_last_word         (iface_last_word),
        .packet_error            (packet_error),
        .lane_source             (lane_source),
        .payload_bytes           (payload_bytes),
        .crc_high_only           (crc_high_only),
        .load_word               (load_word),
        .crc_clear               (crc_clear),
        .crc_update              (crc_update)
    );

    ecc_calc u_ecc (
        .data       (usr_fifo_data[23:0]),          // only meaningful while a header is shown
        .ecc_result (ecc_result)
    );

    crc_calculator u_crc (
        .clk_sys                 (clk_sys),
        .reset_stop_read_data_hs (reset_stop_read_data_hs),
        .clear                   (crc_clear),
        .data_write              (crc_update),
        .bytes_number            (payload_bytes),
        .data_input              (usr_fifo_data),
        .crc_next                (crc_next),
        .crc                     (crc)
    );

    payload_packer u_packer (
        .clk_sys                 (clk_sys),
        .reset_stop_read_data_hs (reset_stop_read_data_hs),
        .load_word               (load_word),
        .lane_source             (lane_source),
        .payload_bytes           (payload_bytes),
        .crc_high_only           (crc_high_only),
        .usr_fifo_data           (usr_fifo_data),
        .ecc_result              (ecc_result),
        .crc_next                (crc_next),
        .crc                     (crc),
        .iface_write_data        (iface_write_data),
        .iface_write_strb        (iface_write_strb)
    );

endmodule

`default_nettype wire

//--- verif/tb_dsi_ref.svh
// one hamming syndrome column per header bit, D23 first and D0 (data id bit 0) last
localparam logic [143:0] ECC_COLUMNS = {
    6'h3B, 6'h37, 6'h2F, 6'h1F, 6'h38, 6'h34, 6'h32, 6'h31,
    6'h2C, 6'h2A, 6'h29, 6'h26, 6'h25, 6'h23, 6'h1C, 6'h1A,
    6'h19, 6'h16, 6'h15, 6'h13, 6'h0E, 6'h0D, 6'h0B, 6'h07
};

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

function automatic logic [7:0] header_ecc(input logic [31:0] hdr);
    logic [23:0] d;
    logic [7:0]  ecc;
    d   = {hdr[15:8], hdr[7:0], hdr[23:16]};    // D0 to D7 are the data id
    ecc = 8'h00;
    for (int i = 0; i < 24; i++)
    begin
        if (d[i])
            ecc[5:0] = ecc[5:0] ^ ECC_COLUMNS[6*i +: 6];
    end
    return ecc;
endfunction

function automatic logic [15:0] crc_add_byte(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] c;
    logic        feedback;
    c = crc;
    for (int i = 0; i < 8; i++)
    begin
        feedback = c[0] ^ b[i];                     // data enters lsb first
        c        = c >> 1;
        if (feedback)
            c = c ^ 16'h8408;
    end
    return c;
endfunction

function automatic packet_kind_e kind_of(input logic [7:0] data_id);
    if (data_id[3:0] == 4'h0 || data_id[3:0] == 4'hF)
        return PKT_RESERVED;
    return (data_id[3] && data_id[2:0] != 3'b000) ? PKT_LONG : PKT_SHORT;
endfunction

// expected words of one packet as {last, strobe, data}, with the payload taken from pay_q
function automatic void expect_packet(input logic [31:0] hdr);
    logic [7:0]  link_bytes [$];
    logic [15:0] crc;
    logic [31:0] word;
    logic [3:0]  strb;
    crc = 16'hFFFF;
    if (kind_of(hdr[23:16]) == PKT_RESERVED)
    begin
        errors_expected++;
        return;
    end
    exp_q.push_back({kind_of(hdr[23:16]) == PKT_SHORT, 4'b1111, header_ecc(hdr),
                     hdr[15:8], hdr[7:0], hdr[23:16]});
    if (kind_of(hdr[23:16]) == PKT_SHORT)
        return;
    for (int i = 0; i < hdr[15:0]; i++)
    begin
        link_bytes.push_back(pay_q[i / 4][8 * (i % 4) +: 8]);
        crc = crc_add_byte(crc, link_bytes[i]);
    end
    link_bytes.push_back(crc[7:0]);
    link_bytes.push_back(crc[15:8]);
    for (int i = 0; i < link_bytes.size(); i += 4)
    begin
        word = '0;
        strb = '0;
        for (int k = 0; k < 4 && i + k < link_bytes.size(); k++)
        begin
            word[8 * k +: 8] = link_bytes[i + k];
            strb[k]          = 1'b1;
        end
        exp_q.push_back({i + 4 >= link_bytes.size(), strb, word});
    end
endfunction

//--- verif/tb_packets_assembler.sv
`default_nettype none

module tb_packets_assembler;
    timeunit 1ns;
    timeprecision 1ps;
    import dsi_pkg::*;

    localparam logic [31:0] SEED      = 32'hcb7dc325;
    localparam logic [31:0] SHORT_IDS = 32'hC8_23_15_05;   // 8'hC8 has bit 3 set but stays short
    localparam logic [31:0] LONG_IDS  = 32'h1A_4E_29_39;

    logic        clk_sys = 1'b0;
    logic        reset_stop_read_data_hs;
    logic [31:0] usr_fifo_data;
    logic        usr_fifo_empty;
    logic        iface_data_rqst;
    logic        usr_fifo_read;
    logic [31:0] iface_write_data;
    strb_t       iface_write_strb;
    logic        iface_write_rqst;
    logic        iface_last_word;
    logic        packet_error;

    logic [31:0] src_q [$];                         // words still waiting to enter the fifo
    logic [31:0] fifo_q [$];
    logic [31:0] pay_q [$];
    logic [36:0] exp_q [$];
    logic [36:0] got_word;
    logic [36:0] held_word;
    logic [31:0] stim_rng = SEED;
    logic [31:0] bus_rng = SEED;
    logic        pop;
    logic        held = 1'b0;
    logic        acc_prev = 1'b0;
    logic        read_prev = 1'b0;
    int          feed_div = 1;                      // a word enters the fifo in 1 of feed_div cycles
    int          stall_level = 0;                   // iface_data_rqst low in stall_level of 8 cycles
    int          errors_expected = 0;
    int          errors_seen = 0;
    string       test_name = "reset";

    `include "tb_dsi_ref.svh"

    packets_assembler u_dut (.*);

    always #50 clk_sys = ~clk_sys;

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_problem(input string what);
        $display("Error in %s: %s", test_name, what);
        stop_run();
    endtask

    task automatic report_mismatch(input string what, input logic [36:0] expected,
                                   input logic [36:0] actual);
        $display("Fail %s %s expected %h actual %h", test_name, what, expected, actual);
        stop_run();
    endtask

    task automatic check_word(input logic [36:0] got);
        logic [36:0] expected;
        logic [31:0] mask;
        assert (exp_q.size() > 0)
            else report_problem("the DUT sent a word that no queued packet explains");
        expected = exp_q.pop_front();
        mask     = {{8{expected[35]}}, {8{expected[34]}}, {8{expected[33]}}, {8{expected[32]}}};
        assert ({got[36:32], got[31:0] & mask} === expected)
            else report_mismatch("word", expected, got);
    endtask

    task automatic send_packet(input logic [7:0] data_id, input logic [15:0] wc);
        logic [31:0] hdr;
        stim_rng = xorshift32(stim_rng);
        hdr      = {stim_rng[31:24], data_id, wc};  // the top byte is ignored by the DUT
        pay_q    = {};
        src_q.push_back(hdr);
        if (kind_of(data_id) == PKT_LONG)
        begin
            for (int i = 0; i < (wc + 3) / 4; i++)
            begin
                stim_rng = xorshift32(stim_rng);
                pay_q.push_back(stim_rng);
                src_q.push_back(stim_rng);
            end
        end
        expect_packet(hdr);
    endtask

    task automatic wait_drained(input int limit);
        for (int n = 0; n < limit; n++)
        begin
            @(posedge clk_sys);
            if (src_q.size() == 0 && fifo_q.size() == 0 && exp_q.size() == 0
                && !iface_write_rqst && !packet_error)
                return;
        end
        report_problem("timed out waiting for all expected words to come out");
    endtask

    // show-ahead fifo model and random back-pressure, inputs change on the falling edge
    always
    begin
        @(posedge clk_sys);
        pop = usr_fifo_read;
        @(negedge clk_sys);
        if (pop === 1'b1)
        begin
            assert (fifo_q.size() > 0)
                else report_problem("the DUT popped an empty FIFO");
            fifo_q.delete(0);
        end
        bus_rng = xorshift32(bus_rng);
        if (src_q.size() > 0 && bus_rng[7:0] % feed_div == 0)
            fifo_q.push_back(src_q.pop_front());
        usr_fifo_empty  = (fifo_q.size() == 0);
        usr_fifo_data   = usr_fifo_empty ? bus_rng : fifo_q[0];  // junk while empty
        iface_data_rqst = (bus_rng[18:16] >= stall_level);
    end

    always @(posedge clk_sys)
    begin
        if (!reset_stop_read_data_hs)
        begin
            got_word = {iface_last_word, iface_write_strb, iface_write_data};
            if (held)
                assert (iface_write_rqst && got_word === held_word)
                    else report_problem("a stalled word changed or was withdrawn");
            if (acc_prev)
                assert (!iface_write_rqst)
                    else report_problem("the request stayed high after an accepted word");
            if (read_prev)
                assert (iface_write_rqst || packet_error)
                    else report_problem("no word or error came one cycle after a FIFO pop");
            if (packet_error === 1'b1)
                errors_seen++;
            if (iface_write_rqst && iface_data_rqst)
                check_word(got_word);
            held      = iface_write_rqst && !iface_data_rqst;
            held_word = got_word;
            acc_prev  = iface_write_rqst && iface_data_rqst;
            read_prev = usr_fifo_read;
        end
    end

    initial
    begin
        reset_stop_read_data_hs = 1'b1;
        usr_fifo_data           = 32'h0;
        usr_fifo_empty          = 1'b1;
        iface_data_rqst         = 1'b0;
        repeat (16) @(negedge clk_sys);
        reset_stop_read_data_hs = 1'b0;
        assert (!iface_write_rqst && !usr_fifo_read && !packet_error)
            else report_problem("an output was not low after reset");
        wait_drained(10);

        test_name = "short_packets";
        for (int i = 0; i < 8; i++)
            send_packet(SHORT_IDS[8 * (i % 4) +: 8], stim_rng[15:0]);
        wait_drained(200);

        test_name = "long_tail_cases";
        for (int wc = 0; wc < 10; wc++)
            send_packet(LONG_IDS[8 * (wc % 4) +: 8], wc);
        wait_drained(500);

        test_name   = "back_pressure";
        stall_level = 5;
        for (int wc = 0; wc < 14; wc++)
            send_packet(LONG_IDS[8 * (wc % 4) +: 8], wc);
        wait_drained(2000);

        test_name   = "fifo_underrun";
        feed_div    = 5;
        stall_level = 2;
        for (int wc = 5; wc < 21; wc++)
            send_packet(LONG_IDS[8 * (wc % 4) +: 8], wc);
        wait_drained(5000);

        test_name   = "reserved_types";
        feed_div    = 1;
        stall_level = 0;
        send_packet(8'h00, 16'h1234);
        send_packet(8'h3F, 16'h0008);
        send_packet(8'hF0, 16'hFFFF);
        send_packet(8'h29, 16'd7);
        send_packet(8'h05, 16'hA55A);
        wait_drained(500);

        test_name   = "random_mix";
        feed_div    = 2;
        stall_level = 3;
        for (int i = 0; i < 300; i++)
        begin
            stim_rng = xorshift32(stim_rng);
            if (kind_of(stim_rng[7:0]) == PKT_LONG)
                send_packet(stim_rng[7:0], {10'h000, stim_rng[21:16]});
            else
                send_packet(stim_rng[7:0], stim_rng[31:16]);
        end
        wait_drained(100000);

        test_name = "end_of_run";
        assert (errors_seen == errors_expected)
            else report_mismatch("packet_error pulses", errors_expected, errors_seen);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+verif
source/dsi_pkg.sv
source/ecc_calc.sv
source/crc_calculator.sv
source/payload_packer.sv
source/packet_sequencer.sv
source/packets_assembler.sv
verif/tb_packets_assembler.sv
